// ==== accel_wrap.f ====
rtl/accel_pkg.sv
rtl/simple_fifo.sv
rtl/pkt_rd_dma.sv
rtl/pattern_matcher.sv
rtl/ip_match.sv
rtl/accel_wrap.sv
dv/accel_wrap_properties.sv
dv/tb_accel_wrap.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench from the project root; exit status is the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_accel_wrap -f accel_wrap.f -o sim_accel_wrap &&
./obj_dir/sim_accel_wrap || {
  echo "Simulation returned a failing status"
  exit 1
}

// ==== dv/accel_stim.txt ====
# op addr value extra test_name, numbers in hex
# M mem line, R rule entry, W io write, C io read (extra 1 = stall), P poll (value mask, extra expected)
M 10 11111111 0 load_pkt_a
M 11 CAFEBABE 0 load_pkt_a
M 12 DEADBEEF 0 load_pkt_a
M 13 01234567 0 load_pkt_a
M 20 13572468 0 load_pkt_b
M 21 0F0F0F0F 0 load_pkt_b
M 22 CAFEBABE 0 load_pkt_b
R 01 000111111111 0 rule_invalid_entry
R 02 10022DEADBEEF 0 rule_load
R 03 10033CAFEBABE 0 rule_load
R 07 10077CAFEBABE 0 rule_load
R 10 10000000A0000 0 prefix_load
R 13 1000000C0A801 0 prefix_load
C 70 00000000 0 reset_dma_status
C 30 00000000 0 unmapped_read
W 04 00000000 0 zero_len_desc
W 00 00000001 0 zero_len_desc
P 70 01000000 01000000 zero_len_desc_wait
C 70 01000000 0 zero_len_desc_err
W 04 00000010 0 len_readback
C 04 00000010 0 len_readback
W 08 00000010 0 addr_readback
C 08 00000010 0 addr_readback
W 10 A5A5A5A5 0 pkt_a_setup
W 18 00000003 0 pkt_a_setup
W 00 00000001 0 pkt_a_start
P 70 00000101 00000100 pkt_a_done_wait
C 70 00000100 0 pkt_a_done_status
C 00 00000001 0 pkt_a_match
C 1C 00000033 0 pkt_a_rule_id
C 10 A1C4F582 0 pkt_a_state
C 18 00000103 0 pkt_a_slot
W 00 00000002 0 release_a
C 00 00000000 0 release_clears_match
W 04 0000000A 0 pkt_b_setup
W 08 00000020 0 pkt_b_setup
W 10 0000FFFF 0 pkt_b_setup
W 18 00000007 0 pkt_b_setup
W 00 00000001 0 pkt_b_start
P 18 00000100 00000100 pkt_b_queue_wait
C 70 00000100 0 pkt_b_done_status
C 00 00000000 0 pkt_b_no_match
C 10 1C586E26 0 pkt_b_state
C 18 00000107 0 pkt_b_slot
W 40 0501A8C0 0 ip_blocked
C 60 00000001 1 ip_blocked_result
C 40 0501A8C0 0 src_ip_readback
W 40 0502A8C0 0 ip_allowed
C 60 00000000 1 ip_allowed_result
W 04 00000010 0 range_desc
W 08 000000FE 0 range_desc
W 00 00000001 0 range_desc
P 70 01000000 01000000 range_desc_wait
C 70 01000100 0 range_desc_err

// ==== dv/tb_accel_wrap.sv ====
`timescale 1ns/1ps

module tb_accel_wrap;

  import accel_pkg::*;

  localparam int    RD_TIMEOUT = 64;
  localparam int    POLL_LIMIT = 100;
  localparam string STIM_FILE  = "dv/accel_stim.txt";

  logic       clk = 1'b0;
  logic       rst;
  logic       io_en;
  logic       io_wen;
  io_strb_t   io_strb;
  io_addr_t   io_addr;
  io_data_t   io_wr_data;
  io_data_t   io_rd_data;
  logic       io_rd_valid;
  logic       rule_wr_en;
  rule_addr_t rule_wr_addr;
  rule_data_t rule_wr_data;
  logic       mem_rd_en;
  mem_addr_t  mem_rd_addr;
  io_data_t   mem_rd_data = '0;

  // Packet memory, one cycle read latency
  io_data_t   mem [MEM_LINES];

  int          fd;
  int          nread;
  int          nfields;
  string       line;
  string       name;
  byte         op;
  logic [63:0] f_a;
  logic [63:0] f_b;
  logic [63:0] f_c;
  io_data_t    rd_data;
  logic        rd_stall;

  accel_wrap i_accel_wrap (
    .clk          (clk),
    .rst          (rst),
    .io_en        (io_en),
    .io_wen       (io_wen),
    .io_strb      (io_strb),
    .io_addr      (io_addr),
    .io_wr_data   (io_wr_data),
    .io_rd_data   (io_rd_data),
    .io_rd_valid  (io_rd_valid),
    .rule_wr_en   (rule_wr_en),
    .rule_wr_addr (rule_wr_addr),
    .rule_wr_data (rule_wr_data),
    .mem_rd_en    (mem_rd_en),
    .mem_rd_addr  (mem_rd_addr),
    .mem_rd_data  (mem_rd_data)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    if (mem_rd_en) begin
      mem_rd_data <= mem[mem_rd_addr];
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_data(input string test, input io_data_t exp, input io_data_t act);
    if (act !== exp) begin
      abort_run($sformatf("Error: %s expected %h actual %h", test, exp, act));
    end
  endtask

  task automatic check_valid(input string test, input logic exp_stall, input logic act_stall);
    if (act_stall !== exp_stall) begin
      abort_run($sformatf("Error: %s expected stall %0b actual stall %0b",
                          test, exp_stall, act_stall));
    end
  endtask

  task automatic io_write(input io_addr_t addr, input io_data_t data);
    @(posedge clk);
    io_en      <= 1'b1;
    io_wen     <= 1'b1;
    io_strb    <= 4'hF;
    io_addr    <= addr;
    io_wr_data <= data;
    @(posedge clk);
    io_en  <= 1'b0;
    io_wen <= 1'b0;
  endtask

  // Address stays put until the answer arrives
  task automatic io_read(input io_addr_t addr, output io_data_t data, output logic stalled);
    int waited;
    waited = 0;
    @(posedge clk);
    io_en   <= 1'b1;
    io_wen  <= 1'b0;
    io_addr <= addr;
    @(posedge clk);
    io_en <= 1'b0;
    @(negedge clk);
    while (!io_rd_valid && waited < RD_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!io_rd_valid) begin
      abort_run($sformatf("Timeout waiting for io_rd_valid after a read of address %h", addr));
    end
    data    = io_rd_data;
    stalled = (waited > 0);
  endtask

  task automatic rule_write(input rule_addr_t addr, input rule_data_t data);
    @(posedge clk);
    rule_wr_en   <= 1'b1;
    rule_wr_addr <= addr;
    rule_wr_data <= data;
    @(posedge clk);
    rule_wr_en <= 1'b0;
  endtask

  task automatic poll_until(input string test, input io_addr_t addr,
                            input io_data_t mask, input io_data_t exp);
    io_data_t data;
    logic     stalled;
    int       tries;
    tries = 0;
    io_read(addr, data, stalled);
    while (((data & mask) !== exp) && tries < POLL_LIMIT) begin
      io_read(addr, data, stalled);
      tries++;
    end
    if ((data & mask) !== exp) begin
      abort_run($sformatf("Timeout in %s while polling address %h for %h under mask %h",
                          test, addr, exp, mask));
    end
  endtask

  initial begin
    rst          <= 1'b1;
    io_en        <= 1'b0;
    io_wen       <= 1'b0;
    io_strb      <= '0;
    io_addr      <= '0;
    io_wr_data   <= '0;
    rule_wr_en   <= 1'b0;
    rule_wr_addr <= '0;
    rule_wr_data <= '0;
    // Fill tied to every address bit
    for (int i = 0; i < MEM_LINES; i++) begin
      mem[i] = {~i[7:0], i[7:0], i[7:0] ^ 8'h5A, i[7:0]};
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      abort_run({"Could not open the stimulus file ", STIM_FILE});
    end
    while (!$feof(fd)) begin
      line  = "";
      nread = $fgets(line, fd);
      if (nread == 0 || line.len() < 2 || line[0] == "#") begin
        continue;
      end
      nfields = $sscanf(line, "%c %h %h %h %s", op, f_a, f_b, f_c, name);
      if (nfields != 5) begin
        abort_run({"Malformed line in the stimulus file: ", line});
      end
      case (op)
        "M": mem[f_a[7:0]] = f_b[31:0];
        "R": rule_write(rule_addr_t'(f_a), rule_data_t'(f_b));
        "W": io_write(io_addr_t'(f_a), io_data_t'(f_b));
        "C": begin
          io_read(io_addr_t'(f_a), rd_data, rd_stall);
          check_valid(name, f_c[0], rd_stall);
          check_data(name, io_data_t'(f_b), rd_data);
        end
        "P": poll_until(name, io_addr_t'(f_a), io_data_t'(f_b), io_data_t'(f_c));
        default: abort_run({"Unknown operation in the stimulus file: ", line});
      endcase
    end
    $fclose(fd);

    $display("Everything OK");
    $finish;
  end

endmodule

// ==== dv/accel_wrap_properties.sv ====
`timescale 1ns/1ps

module accel_wrap_properties (
  input logic                clk,
  input logic                rst,
  input logic                io_en,
  input logic                io_wen,
  input logic                io_rd_valid,
  input logic                s_valid,
  input logic                s_ready,
  input accel_pkg::io_data_t s_data,
  input logic                mem_rd_en,
  input logic                busy
);

  logic rd_pending;
  logic word_in_flight;

  // Open read request, cleared by its answer
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pending <= 1'b0;
    end else if (io_en && !io_wen) begin
      rd_pending <= 1'b1;
    end else if (io_rd_valid) begin
      rd_pending <= 1'b0;
    end
  end

  // One memory word between a read and the beat that carries it
  always_ff @(posedge clk) begin
    if (rst) begin
      word_in_flight <= 1'b0;
    end else if ((s_valid && s_ready) || !busy) begin
      word_in_flight <= 1'b0;
    end else if (mem_rd_en) begin
      word_in_flight <= 1'b1;
    end
  end

  a_stream_hold: assert property (
    @(posedge clk) disable iff (rst) (s_valid && !s_ready) |=> $stable(s_data))
    else $error("s_data changed while the beat was held back");

  a_rd_answer: assert property (
    @(posedge clk) disable iff (rst) io_rd_valid |-> rd_pending)
    else $error("io_rd_valid without an open read request");

  a_one_in_flight: assert property (
    @(posedge clk) disable iff (rst) mem_rd_en |-> !word_in_flight)
    else $error("second memory read before the previous word was taken");

endmodule

bind accel_wrap accel_wrap_properties i_accel_wrap_properties (
  .clk         (clk),
  .rst         (rst),
  .io_en       (io_en),
  .io_wen      (io_wen),
  .io_rd_valid (io_rd_valid),
  .s_valid     (s_valid),
  .s_ready     (s_ready),
  .s_data      (s_data),
  .mem_rd_en   (mem_rd_en),
  .busy        (dma_busy)
);

// ==== rtl/accel_wrap.sv ====
`timescale 1ns/1ps

module accel_wrap (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   io_en,
  input  logic                   io_wen,
  input  accel_pkg::io_strb_t    io_strb,
  input  accel_pkg::io_addr_t    io_addr,
  input  accel_pkg::io_data_t    io_wr_data,
  output accel_pkg::io_data_t    io_rd_data,
  output logic                   io_rd_valid,
  input  logic                   rule_wr_en,
  input  accel_pkg::rule_addr_t  rule_wr_addr,
  input  accel_pkg::rule_data_t  rule_wr_data,
  output logic                   mem_rd_en,
  output accel_pkg::mem_addr_t   mem_rd_addr,
  input  accel_pkg::io_data_t    mem_rd_data
);

  import accel_pkg::*;

  logic       wr_req;
  logic       rd_req;
  io_addr_t   word_addr;

  // Command pulses
  logic       start;
  logic       release_pulse;
  logic       stop;
  logic       ip_check;

  // Stored command values
  pkt_len_t   len_reg;
  mem_addr_t  addr_reg;
  state_t     seed_reg;
  slot_t      slot_reg;
  io_data_t   src_ip_reg;

  io_data_t   read_data;
  logic       read_valid;
  logic       ip_stall;

  logic       dma_busy;
  logic       dma_desc_err;
  logic       dma_done;
  logic       dma_done_err;
  logic       busy_q;
  logic       job_push;

  io_data_t   s_data;
  logic       s_valid;
  logic       s_ready;
  logic       s_last;
  logic [2:0] s_bytes;
  logic       beat_last;

  state_t     head_seed;
  logic       seed_valid;
  logic       seed_pop;
  slot_t      head_slot;
  logic       match;
  rule_id_t   rule_id;
  state_t     state_out;
  logic       state_out_valid;
  state_t     q_state;
  slot_t      q_slot;
  logic       q_valid;

  io_data_t   src_ip_swap;
  logic       ip_hit;
  logic       ip_done;

  assign wr_req    = io_en && io_wen;
  assign rd_req    = io_en && !io_wen;
  assign word_addr = {io_addr[6:2], 2'b00};

  assign io_rd_data  = read_data;
  assign io_rd_valid = read_valid;

  assign beat_last = s_valid && s_ready && s_last;
  // A job enters the seed and slot queues once the DMA accepts it
  assign job_push  = dma_busy && !busy_q;

  // Network byte order to host order for the prefix check
  assign src_ip_swap = {src_ip_reg[7:0], src_ip_reg[15:8],
                        src_ip_reg[23:16], src_ip_reg[31:24]};

  always_ff @(posedge clk) begin
    if (rst) begin
      start         <= 1'b0;
      release_pulse <= 1'b0;
      stop          <= 1'b0;
      ip_check      <= 1'b0;
      read_valid    <= 1'b0;
      ip_stall      <= 1'b0;
      dma_done      <= 1'b0;
      dma_done_err  <= 1'b0;
      busy_q        <= 1'b0;
    end else begin
      start         <= 1'b0;
      release_pulse <= 1'b0;
      stop          <= 1'b0;
      ip_check      <= 1'b0;
      read_valid    <= 1'b0;
      busy_q        <= dma_busy;

      if (wr_req && word_addr == REG_CTRL && io_strb[0]) begin
        start         <= io_wr_data[0];
        release_pulse <= io_wr_data[1];
        stop          <= io_wr_data[2];
      end
      if (wr_req && word_addr == REG_SRC_IP) begin
        ip_check <= 1'b1;
      end

      // IP result waits for the checker, others answer next cycle
      if (rd_req) begin
        if (word_addr == REG_IP_RES) begin
          read_valid <= ip_done;
          ip_stall   <= !ip_done;
        end else begin
          read_valid <= 1'b1;
        end
      end else if (ip_stall && ip_done) begin
        read_valid <= 1'b1;
        ip_stall   <= 1'b0;
      end

      dma_done     <= dma_done || beat_last || stop;
      dma_done_err <= dma_done_err || (start && dma_done && dma_busy);
    end
  end

  always_ff @(posedge clk) begin
    if (wr_req) begin
      case (word_addr)
        REG_LEN:    len_reg    <= io_wr_data[13:0];
        REG_ADDR:   addr_reg   <= io_wr_data[7:0];
        REG_SEED:   seed_reg   <= io_wr_data;
        REG_SLOT:   slot_reg   <= io_wr_data[7:0];
        REG_SRC_IP: src_ip_reg <= io_wr_data;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_req) begin
      read_data <= '0;
      case (word_addr)
        REG_CTRL:     read_data[0] <= match;
        REG_LEN:      read_data    <= io_data_t'(len_reg);
        REG_ADDR:     read_data    <= io_data_t'(addr_reg);
        REG_SEED:     read_data    <= q_state;
        REG_SLOT:     read_data    <= {23'd0, q_valid, q_slot};
        REG_RULE:     read_data    <= io_data_t'(rule_id);
        REG_SRC_IP:   read_data    <= src_ip_reg;
        REG_IP_RES:   read_data[0] <= ip_hit;
        REG_DMA_STAT: read_data    <= {7'd0, dma_desc_err, 7'd0, dma_done_err,
                                       7'd0, dma_done, 7'd0, dma_busy};
        default: ;
      endcase
    end else if (ip_stall) begin
      read_data <= {31'd0, ip_hit};
    end
  end

  pkt_rd_dma i_pkt_rd_dma (
    .clk         (clk),
    .rst         (rst),
    .desc_addr   (addr_reg),
    .desc_len    (len_reg),
    .desc_valid  (start),
    .stop        (stop),
    .desc_error  (dma_desc_err),
    .busy        (dma_busy),
    .mem_rd_en   (mem_rd_en),
    .mem_rd_addr (mem_rd_addr),
    .mem_rd_data (mem_rd_data),
    .s_data      (s_data),
    .s_valid     (s_valid),
    .s_last      (s_last),
    .s_bytes     (s_bytes),
    .s_ready     (s_ready)
  );

  simple_fifo #(.DEPTH_LOG2(2), .WIDTH($bits(state_t))) seed_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (job_push),
    .din       (seed_reg),
    .pop       (seed_pop),
    .dout      (head_seed),
    .not_empty (seed_valid)
  );

  simple_fifo #(.DEPTH_LOG2(2), .WIDTH($bits(slot_t))) slot_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (job_push),
    .din       (slot_reg),
    .pop       (seed_pop),
    .dout      (head_slot),
    .not_empty ()
  );

  pattern_matcher i_pattern_matcher (
    .clk             (clk),
    .rst             (rst),
    .s_data          (s_data),
    .s_valid         (s_valid),
    .s_last          (s_last),
    .s_bytes         (s_bytes),
    .s_ready         (s_ready),
    .seed            (head_seed),
    .seed_valid      (seed_valid),
    .seed_pop        (seed_pop),
    .rule_wr_en      (rule_wr_en),
    .rule_wr_addr    (rule_wr_addr),
    .rule_wr_data    (rule_wr_data),
    .match_release   (release_pulse),
    .match           (match),
    .rule_id         (rule_id),
    .state_out       (state_out),
    .state_out_valid (state_out_valid)
  );

  // Final state paired with the slot of the same job
  simple_fifo #(.DEPTH_LOG2(2), .WIDTH($bits(state_t) + $bits(slot_t))) state_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (state_out_valid),
    .din       ({state_out, head_slot}),
    .pop       (release_pulse),
    .dout      ({q_state, q_slot}),
    .not_empty (q_valid)
  );

  ip_match i_ip_match (
    .clk          (clk),
    .rst          (rst),
    .rule_wr_en   (rule_wr_en),
    .rule_wr_addr (rule_wr_addr),
    .rule_wr_data (rule_wr_data),
    .addr         (src_ip_swap),
    .check        (ip_check),
    .ip_match     (ip_hit),
    .ip_done      (ip_done)
  );

endmodule

// ==== rtl/ip_match.sv ====
`timescale 1ns/1ps

module ip_match (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rule_wr_en,
  input  accel_pkg::rule_addr_t rule_wr_addr,
  input  accel_pkg::rule_data_t rule_wr_data,
  input  accel_pkg::io_data_t   addr,
  input  logic                  check,
  output logic                  ip_match,
  output logic                  ip_done
);

  import accel_pkg::*;

  localparam int IDX_W = $clog2(PREFIX_COUNT);

  logic [PREFIX_COUNT-1:0] pfx_valid;
  logic [23:0]             pfx [PREFIX_COUNT];
  logic [IDX_W-1:0]        scan_idx;
  logic [IDX_W-1:0]        idx;
  logic                    scanning;
  logic                    done_q;
  logic                    hit;
  logic                    pfx_wr;

  // Entries 16 to 23 of the rule space
  assign pfx_wr = rule_wr_en && rule_wr_addr[4] && !rule_wr_addr[3];

  // Entry 0 is compared in the check cycle itself
  assign idx = check ? '0 : scan_idx;
  assign hit = pfx_valid[idx] && (pfx[idx] == addr[31:8]);

  assign ip_done = done_q && !check;

  always_ff @(posedge clk) begin
    if (rst) begin
      pfx_valid <= '0;
      scanning  <= 1'b0;
      done_q    <= 1'b0;
      ip_match  <= 1'b0;
      scan_idx  <= '0;
    end else begin
      if (pfx_wr) begin
        pfx_valid[rule_wr_addr[2:0]] <= rule_wr_data[48];
      end
      if (check) begin
        scanning <= 1'b1;
        done_q   <= 1'b0;
        ip_match <= hit;
        scan_idx <= IDX_W'(1);
      end else if (scanning) begin
        ip_match <= ip_match || hit;
        scan_idx <= scan_idx + 1'b1;
        if (scan_idx == IDX_W'(PREFIX_COUNT - 1)) begin
          scanning <= 1'b0;
          done_q   <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pfx_wr) begin
      pfx[rule_wr_addr[2:0]] <= rule_wr_data[23:0];
    end
  end

endmodule

// ==== rtl/pattern_matcher.sv ====
`timescale 1ns/1ps

module pattern_matcher (
  input  logic                  clk,
  input  logic                  rst,
  input  accel_pkg::io_data_t   s_data,
  input  logic                  s_valid,
  input  logic                  s_last,
  input  logic [2:0]            s_bytes,
  output logic                  s_ready,
  input  accel_pkg::state_t     seed,
  input  logic                  seed_valid,
  output logic                  seed_pop,
  input  logic                  rule_wr_en,
  input  accel_pkg::rule_addr_t rule_wr_addr,
  input  accel_pkg::rule_data_t rule_wr_data,
  input  logic                  match_release,
  output logic                  match,
  output accel_pkg::rule_id_t   rule_id,
  output accel_pkg::state_t     state_out,
  output logic                  state_out_valid
);

  import accel_pkg::*;

  logic [PATTERN_COUNT-1:0] pat_valid;
  rule_id_t                 pat_id [PATTERN_COUNT];
  io_data_t                 pat_word [PATTERN_COUNT];

  logic     beat;
  logic     full_word;
  logic     hit;
  rule_id_t hit_id;
  io_data_t byte_mask;
  state_t   acc;
  logic     in_pkt;
  state_t   cur_state;

  // Only accept words while a seed for the packet is queued
  assign s_ready   = seed_valid;
  assign beat      = s_valid && s_ready;
  assign full_word = !s_last || (s_bytes == 3'd4);

  // Lowest index wins
  always_comb begin
    hit    = 1'b0;
    hit_id = '0;
    for (int i = PATTERN_COUNT - 1; i >= 0; i--) begin
      if (pat_valid[i] && pat_word[i] == s_data) begin
        hit    = 1'b1;
        hit_id = pat_id[i];
      end
    end
  end

  // Bytes past the packet end do not enter the state
  always_comb begin
    case (s_bytes)
      3'd1:    byte_mask = 32'h0000_00FF;
      3'd2:    byte_mask = 32'h0000_FFFF;
      3'd3:    byte_mask = 32'h00FF_FFFF;
      default: byte_mask = 32'hFFFF_FFFF;
    endcase
  end

  assign cur_state       = in_pkt ? acc : seed;
  assign state_out       = cur_state ^ (s_data & byte_mask);
  assign state_out_valid = beat && s_last;
  assign seed_pop        = beat && s_last;

  always_ff @(posedge clk) begin
    if (rst) begin
      pat_valid <= '0;
      match     <= 1'b0;
      in_pkt    <= 1'b0;
    end else begin
      if (rule_wr_en && !rule_wr_addr[4]) begin
        pat_valid[rule_wr_addr[3:0]] <= rule_wr_data[48];
      end
      if (match_release) begin
        match <= 1'b0;
      end
      if (beat && full_word && hit && !match) begin
        match <= 1'b1;
      end
      if (beat) begin
        in_pkt <= !s_last;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rule_wr_en && !rule_wr_addr[4]) begin
      pat_id[rule_wr_addr[3:0]]   <= rule_wr_data[47:32];
      pat_word[rule_wr_addr[3:0]] <= rule_wr_data[31:0];
    end
    if (beat && full_word && hit && !match) begin
      rule_id <= hit_id;
    end
    if (beat) begin
      acc <= state_out;
    end
  end

endmodule

// ==== rtl/pkt_rd_dma.sv ====
`timescale 1ns/1ps

module pkt_rd_dma (
  input  logic                 clk,
  input  logic                 rst,
  input  accel_pkg::mem_addr_t desc_addr,
  input  accel_pkg::pkt_len_t  desc_len,
  input  logic                 desc_valid,
  input  logic                 stop,
  output logic                 desc_error,
  output logic                 busy,
  output logic                 mem_rd_en,
  output accel_pkg::mem_addr_t mem_rd_addr,
  input  accel_pkg::io_data_t  mem_rd_data,
  output accel_pkg::io_data_t  s_data,
  output logic                 s_valid,
  output logic                 s_last,
  output logic [2:0]           s_bytes,
  input  logic                 s_ready
);

  import accel_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_WAIT,
    S_HOLD
  } dma_state_t;

  dma_state_t  state;
  mem_addr_t   line_addr;
  logic [12:0] words_left;
  logic [2:0]  last_bytes;
  logic [14:0] len_round;
  logic [12:0] desc_lines;
  logic [13:0] desc_end;
  logic        desc_bad;

  // Lines needed, rounded up to whole words
  assign len_round  = {1'b0, desc_len} + 15'd3;
  assign desc_lines = len_round[14:2];
  assign desc_end   = {6'd0, desc_addr} + {1'b0, desc_lines};
  assign desc_bad   = (desc_len == '0) || (desc_end > MEM_LINES);

  assign mem_rd_en   = (state == S_READ);
  assign mem_rd_addr = line_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= S_IDLE;
      busy       <= 1'b0;
      desc_error <= 1'b0;
      s_valid    <= 1'b0;
    end else if (stop) begin
      // Abort without a last beat
      state   <= S_IDLE;
      busy    <= 1'b0;
      s_valid <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (desc_valid) begin
            desc_error <= desc_bad;
            if (!desc_bad) begin
              busy  <= 1'b1;
              state <= S_READ;
            end
          end
        end
        S_READ: state <= S_WAIT;
        S_WAIT: begin
          s_valid <= 1'b1;
          state   <= S_HOLD;
        end
        S_HOLD: begin
          if (s_ready) begin
            s_valid <= 1'b0;
            if (s_last) begin
              busy  <= 1'b0;
              state <= S_IDLE;
            end else begin
              state <= S_READ;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && desc_valid) begin
      line_addr  <= desc_addr;
      words_left <= desc_lines;
      last_bytes <= (desc_len[1:0] == 2'd0) ? 3'd4 : {1'b0, desc_len[1:0]};
    end
    if (state == S_READ) begin
      line_addr <= line_addr + 8'd1;
    end
    // Memory word arrives one cycle after the read
    if (state == S_WAIT) begin
      s_data     <= mem_rd_data;
      s_last     <= (words_left == 13'd1);
      s_bytes    <= (words_left == 13'd1) ? last_bytes : 3'd4;
      words_left <= words_left - 13'd1;
    end
  end

endmodule

// ==== rtl/simple_fifo.sv ====
`timescale 1ns/1ps

module simple_fifo #(
  parameter int DEPTH_LOG2 = 2,
  parameter int WIDTH      = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             push,
  input  logic [WIDTH-1:0] din,
  input  logic             pop,
  output logic [WIDTH-1:0] dout,
  output logic             not_empty
);

  logic [WIDTH-1:0]      mem [2**DEPTH_LOG2];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   count;
  logic                  do_push;
  logic                  do_pop;

  // Top count bit set means full
  assign do_push   = push && !count[DEPTH_LOG2];
  assign do_pop    = pop && not_empty;
  assign not_empty = (count != '0);
  assign dout      = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (do_push ? 1'b1 : 1'b0) - (do_pop ? 1'b1 : 1'b0);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

endmodule

// ==== rtl/accel_pkg.sv ====
package accel_pkg;

  typedef logic [31:0] io_data_t;
  typedef logic [6:0]  io_addr_t;
  typedef logic [3:0]  io_strb_t;
  typedef logic [7:0]  mem_addr_t;
  typedef logic [13:0] pkt_len_t;
  typedef logic [15:0] rule_id_t;
  typedef logic [7:0]  slot_t;
  typedef logic [31:0] state_t;
  typedef logic [4:0]  rule_addr_t;
  // Bit 48 valid, then rule ID and pattern, or a 24-bit prefix in the low bits
  typedef logic [48:0] rule_data_t;

  localparam int PATTERN_COUNT = 16;
  localparam int PREFIX_COUNT  = 8;
  localparam int MEM_LINES     = 256;

  // MMIO byte offsets
  localparam io_addr_t REG_CTRL     = 7'h00;
  localparam io_addr_t REG_LEN      = 7'h04;
  localparam io_addr_t REG_ADDR     = 7'h08;
  localparam io_addr_t REG_SEED     = 7'h10;
  localparam io_addr_t REG_SLOT     = 7'h18;
  localparam io_addr_t REG_RULE     = 7'h1C;
  localparam io_addr_t REG_SRC_IP   = 7'h40;
  localparam io_addr_t REG_IP_RES   = 7'h60;
  localparam io_addr_t REG_DMA_STAT = 7'h70;

endpackage
